/* design/cl_core_macros.svh */
//--------------------------------------------------------------------
// Custom-logic core constants
// ID words, register map, LED default pattern and bus widths
//--------------------------------------------------------------------
`ifndef CL_CORE_MACROS_SVH
`define CL_CORE_MACROS_SVH

// Read-only ID words seen by the host
`define CL_ID0 32'hF000_1D0F
`define CL_ID1 32'h1D51_FEDD

// LED pattern when the host has not taken over
`define CL_VLED_DEFAULT 16'hBEEF

// Bus and field widths
`define CL_AXIL_ADDR_W 32
`define CL_AXIL_DATA_W 32
`define CL_VDIP_W 16
`define CL_GLC_W 64
`define CL_REG_OFFS_W 8

// Management register map, byte offsets
`define REG_ID0 8'h00
`define REG_ID1 8'h04
`define REG_VDIP 8'h08
`define REG_CTRL 8'h0C
`define REG_GLC_LO 8'h10
`define REG_GLC_HI 8'h14
`define REG_SCRATCH 8'h18

// AXI response codes
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`endif

/* design/cl_core_pkg.sv */
//--------------------------------------------------------------------
// Custom-logic core types
// AXI-Lite request and response, re-timed status and control word
//--------------------------------------------------------------------
`include "cl_core_macros.svh"

package cl_core_pkg;

  //--------------------------------------------------------------------
  // AXI-Lite management port
  //--------------------------------------------------------------------

  // Host to card
  typedef struct packed {
    logic                       aw_valid;
    logic [`CL_AXIL_ADDR_W-1:0] aw_addr;
    logic                       w_valid;
    logic [`CL_AXIL_DATA_W-1:0] w_data;
    logic                       b_ready;
    logic                       ar_valid;
    logic [`CL_AXIL_ADDR_W-1:0] ar_addr;
    logic                       r_ready;
  } axil_req_t;

  // Card to host
  typedef struct packed {
    logic                       aw_ready;
    logic                       w_ready;
    logic                       b_valid;
    logic [1:0]                 b_resp;
    logic                       ar_ready;
    logic                       r_valid;
    logic [`CL_AXIL_DATA_W-1:0] r_data;
    logic [1:0]                 r_resp;
  } axil_rsp_t;

  //--------------------------------------------------------------------
  // Shell state and control
  //--------------------------------------------------------------------

  // Shell inputs after re-timing
  typedef struct packed {
    logic [`CL_VDIP_W-1:0] vdip;
    logic [`CL_GLC_W-1:0]  glcount;
  } cl_status_t;

  // Control word fields, MSB first
  // Bit 31 is vled_src, bits 15:0 are vled_val
  typedef struct packed {
    logic        vled_src;
    logic [14:0] rsvd;
    logic [15:0] vled_val;
  } cl_ctrl_fields_t;

  // Slave keeps the raw word, status block decodes the fields
  typedef union packed {
    logic [`CL_AXIL_DATA_W-1:0] raw;
    cl_ctrl_fields_t            fields;
  } cl_ctrl_u;

endpackage

/* design/cl_rst_sync.sv */
//--------------------------------------------------------------------
// Reset synchronizer for the main clock domain
//--------------------------------------------------------------------
`timescale 1ns/1ps

module cl_rst_sync (
  input  logic clk_main_a0,
  input  logic rst_main_n_i,
  output logic rst_main_n_sync_o
);

  // Two-stage chain
  logic pre_sync_q;
  logic sync_q;

  // Assert at once, release after two clean edges
  always_ff @(posedge clk_main_a0 or negedge rst_main_n_i) begin
    if (!rst_main_n_i) begin
      pre_sync_q <= 1'b0;
      sync_q     <= 1'b0;
    end else begin
      pre_sync_q <= 1'b1;
      sync_q     <= pre_sync_q;
    end
  end

  assign rst_main_n_sync_o = sync_q;

  // Release only after the shell reset was high for two edges
  a_rst_release: assert property (@(posedge clk_main_a0)
    $rose(rst_main_n_sync_o) |-> rst_main_n_i && $past(rst_main_n_i));

endmodule

/* design/cl_status_regs.sv */
//--------------------------------------------------------------------
// Shell status re-timing and virtual LED driver
// Syncs DIP switches, flops the global counter, registers the LEDs
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "cl_core_macros.svh"

module cl_status_regs
  import cl_core_pkg::*;
(
  input  logic                  clk_main_a0,
  input  logic                  rst_main_n_sync,
  input  logic [`CL_VDIP_W-1:0] vdip_i,
  input  logic [`CL_GLC_W-1:0]  glcount_i,
  input  cl_ctrl_u              ctrl_i,
  output cl_status_t            status_o,
  output logic [15:0]           vled_o
);

  //--------------------------------------------------------------------
  // Virtual DIP switches
  //--------------------------------------------------------------------

  // Double flop, shell drives these asynchronously
  logic [`CL_VDIP_W-1:0] vdip_q;
  logic [`CL_VDIP_W-1:0] vdip_q2;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q  <= vdip_i;
      vdip_q2 <= vdip_q;
    end
  end

  //--------------------------------------------------------------------
  // Global counter
  //--------------------------------------------------------------------

  // Single flop for timing
  logic [`CL_GLC_W-1:0] glcount_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      glcount_q <= '0;
    end else begin
      glcount_q <= glcount_i;
    end
  end

  // Pack re-timed values for the register slave
  assign status_o.vdip    = vdip_q2;
  assign status_o.glcount = glcount_q;

  //--------------------------------------------------------------------
  // Virtual LEDs
  //--------------------------------------------------------------------

  logic [15:0] vled_nxt;
  logic [15:0] vled_q;

  // Host value only when vled_src is set
  always_comb begin
    if (ctrl_i.fields.vled_src) begin
      vled_nxt = ctrl_i.fields.vled_val;
    end else begin
      vled_nxt = `CL_VLED_DEFAULT;
    end
  end

  // Default pattern straight out of reset
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q <= `CL_VLED_DEFAULT;
    end else begin
      vled_q <= vled_nxt;
    end
  end

  assign vled_o = vled_q;

  // Cleared vled_src gives the default pattern one cycle later
  a_vled_default: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !ctrl_i.fields.vled_src |=> vled_o == `CL_VLED_DEFAULT);

endmodule

/* design/cl_ocl_slave.sv */
//--------------------------------------------------------------------
// AXI-Lite management register slave
// ID, DIP, control, counter and scratch registers with one-deep channels
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "cl_core_macros.svh"

module cl_ocl_slave
  import cl_core_pkg::*;
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  axil_req_t                  req_i,
  output axil_rsp_t                  rsp_o,
  input  cl_status_t                 status_i,
  output cl_ctrl_u                   ctrl_o,
  output logic [`CL_AXIL_DATA_W-1:0] scratch_o
);

  // Register offsets from the low address bits
  logic [`CL_REG_OFFS_W-1:0] wr_offs;
  logic [`CL_REG_OFFS_W-1:0] rd_offs;

  assign wr_offs = req_i.aw_addr[`CL_REG_OFFS_W-1:0];
  assign rd_offs = req_i.ar_addr[`CL_REG_OFFS_W-1:0];

  //--------------------------------------------------------------------
  // Write channel
  //--------------------------------------------------------------------

  logic       wr_ack_q;
  logic       wr_fire;
  logic       wr_hit;
  logic       b_valid_q;
  logic [1:0] b_resp_q;

  // Handshake edge is the cycle with both readies up
  assign wr_fire = wr_ack_q && req_i.aw_valid && req_i.w_valid;

  // Only control and scratch are writable
  assign wr_hit = (wr_offs == `REG_CTRL) || (wr_offs == `REG_SCRATCH);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_ack_q  <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      // One-cycle ready pulse, blocked while a response is pending
      wr_ack_q <= req_i.aw_valid && req_i.w_valid && !wr_ack_q && !b_valid_q;
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // Response code latched at the handshake
  always_ff @(posedge clk_main_a0) begin
    if (wr_fire) begin
      b_resp_q <= wr_hit ? `RESP_OKAY : `RESP_SLVERR;
    end
  end

  //--------------------------------------------------------------------
  // Control and scratch registers
  //--------------------------------------------------------------------

  cl_ctrl_u                   ctrl_q;
  logic [`CL_AXIL_DATA_W-1:0] scratch_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q.raw <= '0;
      scratch_q  <= '0;
    end else if (wr_fire) begin
      if (wr_offs == `REG_CTRL) begin
        ctrl_q.raw <= req_i.w_data;
      end
      if (wr_offs == `REG_SCRATCH) begin
        scratch_q <= req_i.w_data;
      end
    end
  end

  assign ctrl_o    = ctrl_q;
  assign scratch_o = scratch_q;

  //--------------------------------------------------------------------
  // Read channel
  //--------------------------------------------------------------------

  logic                       rd_ack_q;
  logic                       rd_fire;
  logic                       r_valid_q;
  logic [`CL_AXIL_DATA_W-1:0] r_data_q;
  logic [1:0]                 r_resp_q;
  logic [`CL_AXIL_DATA_W-1:0] rd_data;
  logic [1:0]                 rd_resp;
  logic [`CL_AXIL_DATA_W-1:0] glc_hi_q;

  assign rd_fire = rd_ack_q && req_i.ar_valid;

  // Read mux
  always_comb begin
    rd_data = '0;
    rd_resp = `RESP_OKAY;
    case (rd_offs)
      `REG_ID0:     rd_data = `CL_ID0;
      `REG_ID1:     rd_data = `CL_ID1;
      `REG_VDIP:    rd_data = {{(`CL_AXIL_DATA_W-`CL_VDIP_W){1'b0}}, status_i.vdip};
      `REG_CTRL:    rd_data = ctrl_q.raw;
      `REG_GLC_LO:  rd_data = status_i.glcount[31:0];
      `REG_GLC_HI:  rd_data = glc_hi_q;
      `REG_SCRATCH: rd_data = scratch_q;
      default:      rd_resp = `RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_ack_q  <= 1'b0;
      r_valid_q <= 1'b0;
      glc_hi_q  <= '0;
    end else begin
      rd_ack_q <= req_i.ar_valid && !rd_ack_q && !r_valid_q;
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
      // Low-half read freezes the high half for a coherent 64-bit value
      if (rd_fire && (rd_offs == `REG_GLC_LO)) begin
        glc_hi_q <= status_i.glcount[63:32];
      end
    end
  end

  // Read payload, held until the host takes it
  always_ff @(posedge clk_main_a0) begin
    if (rd_fire) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  //--------------------------------------------------------------------
  // Response outputs
  //--------------------------------------------------------------------

  assign rsp_o.aw_ready = wr_ack_q;
  assign rsp_o.w_ready  = wr_ack_q;
  assign rsp_o.b_valid  = b_valid_q;
  assign rsp_o.b_resp   = b_resp_q;
  assign rsp_o.ar_ready = rd_ack_q;
  assign rsp_o.r_valid  = r_valid_q;
  assign rsp_o.r_data   = r_data_q;
  assign rsp_o.r_resp   = r_resp_q;

  // Write response waits for the host
  a_b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp_o.b_valid && !req_i.b_ready |=> rsp_o.b_valid);

  // Read data frozen under back-pressure
  a_r_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rsp_o.r_valid && !req_i.r_ready |=> rsp_o.r_valid && $stable(rsp_o.r_data));

endmodule

/* design/cl_core_top.sv */
//--------------------------------------------------------------------
// Custom-logic core top
// Reset sync, shell status re-timing and the management register slave
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "cl_core_macros.svh"

module cl_core_top
  import cl_core_pkg::*;
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_i,
  // Host management port
  input  axil_req_t                  ocl_req_i,
  output axil_rsp_t                  ocl_rsp_o,
  // Shell status
  input  logic [`CL_VDIP_W-1:0]      vdip_i,
  input  logic [`CL_GLC_W-1:0]       glcount_i,
  output logic [15:0]                vled_o,
  output logic [`CL_AXIL_DATA_W-1:0] status0_o,
  output logic [`CL_AXIL_DATA_W-1:0] status1_o
);

  //--------------------------------------------------------------------
  // Internal signals
  //--------------------------------------------------------------------

  logic                       rst_main_n_sync;
  cl_status_t                 status;
  cl_ctrl_u                   ctrl;
  logic [`CL_AXIL_DATA_W-1:0] scratch;

  //--------------------------------------------------------------------
  // Reset
  //--------------------------------------------------------------------

  cl_rst_sync u_rst_sync (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_i      (rst_main_n_i),
    .rst_main_n_sync_o (rst_main_n_sync)
  );

  //--------------------------------------------------------------------
  // Shell status and LEDs
  //--------------------------------------------------------------------

  cl_status_regs u_status_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vdip_i          (vdip_i),
    .glcount_i       (glcount_i),
    .ctrl_i          (ctrl),
    .status_o        (status),
    .vled_o          (vled_o)
  );

  //--------------------------------------------------------------------
  // Management register slave
  //--------------------------------------------------------------------

  cl_ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req_i           (ocl_req_i),
    .rsp_o           (ocl_rsp_o),
    .status_i        (status),
    .ctrl_o          (ctrl),
    .scratch_o       (scratch)
  );

  // Shell status words mirror control and scratch
  assign status0_o = ctrl.raw;
  assign status1_o = scratch;

endmodule

/* verif/tb_clk_gen.sv */
//----------------------------------------------------------------------
// Testbench clock and reset source, 4 ns clock
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, 2 ns half period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Shell reset low for the first 3 cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* verif/tb_cl_core.sv */
//----------------------------------------------------------------------
// Testbench for the custom-logic core
// Table-driven AXI-Lite register traffic with shell status checks
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cl_core_macros.svh"

module tb_cl_core
  import cl_core_pkg::*;
();

  // Cycles any single wait may take
  localparam int TIMEOUT = 200;

  // Table operations: bus access, shell input update, output check
  typedef enum logic [2:0] {OP_WR, OP_RD, OP_VDIP, OP_GLC, OP_VLED, OP_STAT0, OP_STAT1} op_e;

  typedef struct packed {
    op_e         op;
    logic [7:0]  offs;
    logic [63:0] wdata;
    logic [63:0] exp;
    logic [1:0]  resp;
    logic [3:0]  hold;
  } entry_t;

  logic        clk;
  logic        rst_n;
  axil_req_t   req;
  axil_rsp_t   rsp;
  logic [15:0] vdip;
  logic [63:0] glc;
  logic [15:0] vled;
  logic [31:0] status0;
  logic [31:0] status1;
  entry_t      table_q[$];

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cl_core_top dut (
    .clk_main_a0  (clk),
    .rst_main_n_i (rst_n),
    .ocl_req_i    (req),
    .ocl_rsp_o    (rsp),
    .vdip_i       (vdip),
    .glcount_i    (glc),
    .vled_o       (vled),
    .status0_o    (status0),
    .status1_o    (status1)
  );

  //----------------------------------------------------------------------
  // Checking
  //----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Checks failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out while waiting for %s", what);
    $display("Checks failed");
    $fatal(1, "Wait timed out");
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  //----------------------------------------------------------------------
  // AXI-Lite host side
  //----------------------------------------------------------------------

  // Address and data together, then the write response
  task automatic axil_write(input logic [7:0] offs, input logic [31:0] data,
                            input logic [3:0] hold, output logic [1:0] resp);
    int cnt;
    @(posedge clk);
    req.aw_valid <= 1'b1;
    req.aw_addr  <= {24'h0, offs};
    req.w_valid  <= 1'b1;
    req.w_data   <= data;
    cnt = 0;
    @(negedge clk);
    while (!rsp.aw_ready) begin
      cnt++;
      if (cnt > TIMEOUT) timeout_fail("aw_ready");
      @(negedge clk);
    end
    check_value("w_ready", 64'(rsp.w_ready), 64'd1);
    // Handshake completes on this edge
    // Under back-pressure the host offers the next write at once
    @(posedge clk);
    req.aw_valid <= (hold != 4'd0);
    req.w_valid  <= (hold != 4'd0);
    cnt = 0;
    @(negedge clk);
    while (!rsp.b_valid) begin
      cnt++;
      if (cnt > TIMEOUT) timeout_fail("b_valid");
      @(negedge clk);
    end
    resp = rsp.b_resp;
    // Response holds and the offered write is refused
    repeat (hold) begin
      @(negedge clk);
      check_value("b_valid", 64'(rsp.b_valid), 64'd1);
      check_value("b_resp", 64'(rsp.b_resp), 64'(resp));
      check_value("aw_ready", 64'(rsp.aw_ready), 64'd0);
    end
    @(posedge clk);
    req.aw_valid <= 1'b0;
    req.w_valid  <= 1'b0;
    req.b_ready  <= 1'b1;
    @(posedge clk);
    req.b_ready <= 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] offs, input logic [3:0] hold,
                           output logic [31:0] data, output logic [1:0] resp);
    int cnt;
    @(posedge clk);
    req.ar_valid <= 1'b1;
    req.ar_addr  <= {24'h0, offs};
    cnt = 0;
    @(negedge clk);
    while (!rsp.ar_ready) begin
      cnt++;
      if (cnt > TIMEOUT) timeout_fail("ar_ready");
      @(negedge clk);
    end
    // Under back-pressure the host offers the next read at once
    @(posedge clk);
    req.ar_valid <= (hold != 4'd0);
    cnt = 0;
    @(negedge clk);
    while (!rsp.r_valid) begin
      cnt++;
      if (cnt > TIMEOUT) timeout_fail("r_valid");
      @(negedge clk);
    end
    data = rsp.r_data;
    resp = rsp.r_resp;
    // Read data frozen while the host stalls
    repeat (hold) begin
      @(negedge clk);
      check_value("r_valid", 64'(rsp.r_valid), 64'd1);
      check_value("r_data", 64'(rsp.r_data), 64'(data));
      check_value("ar_ready", 64'(rsp.ar_ready), 64'd0);
    end
    @(posedge clk);
    req.ar_valid <= 1'b0;
    req.r_ready  <= 1'b1;
    @(posedge clk);
    req.r_ready <= 1'b0;
  endtask

  //----------------------------------------------------------------------
  // Stimulus table
  //----------------------------------------------------------------------

  function automatic void add_entry(input op_e op, input logic [7:0] offs,
                                    input logic [63:0] wdata, input logic [63:0] exp,
                                    input logic [1:0] resp, input logic [3:0] hold);
    table_q.push_back(entry_t'{op, offs, wdata, exp, resp, hold});
  endfunction

  task automatic run_entry(input entry_t e);
    logic [31:0] rdata;
    logic [1:0]  resp;
    case (e.op)
      OP_WR: begin
        axil_write(e.offs, e.wdata[31:0], e.hold, resp);
        check_value("b_resp", 64'(resp), 64'(e.resp));
      end
      OP_RD: begin
        axil_read(e.offs, e.hold, rdata, resp);
        check_value("r_data", 64'(rdata), e.exp);
        check_value("r_resp", 64'(resp), 64'(e.resp));
      end
      // DIP value needs two cycles through the sync stages
      OP_VDIP: begin
        @(posedge clk);
        vdip <= e.wdata[15:0];
        wait_cycles(3);
      end
      OP_GLC: begin
        @(posedge clk);
        glc <= e.wdata;
        wait_cycles(2);
      end
      OP_VLED: begin
        @(negedge clk);
        check_value("vled_o", 64'(vled), e.exp);
      end
      OP_STAT0: begin
        @(negedge clk);
        check_value("status0_o", 64'(status0), e.exp);
      end
      OP_STAT1: begin
        @(negedge clk);
        check_value("status1_o", 64'(status1), e.exp);
      end
      default: begin
      end
    endcase
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------

  initial begin
    logic [15:0] vdip_r;
    logic [63:0] glc_r;
    logic [15:0] led_r;
    logic [31:0] ctrl_on;
    logic [31:0] ctrl_off;
    logic [31:0] scr [3];
    int          cnt;
    req  = '0;
    vdip = '0;
    glc  = '0;
    void'($urandom(37369));
    vdip_r   = 16'($urandom);
    glc_r    = {$urandom, $urandom};
    led_r    = 16'($urandom);
    scr[0]   = $urandom;
    scr[1]   = $urandom;
    scr[2]   = $urandom;
    // LED override on, then back to the default pattern
    ctrl_on  = {1'b1, 15'h0, led_r};
    ctrl_off = {1'b0, 15'h0, led_r};

    // Idle state and ID words
    add_entry(OP_VLED, 8'h0, 64'd0, 64'(`CL_VLED_DEFAULT), 2'd0, 4'd0);
    add_entry(OP_STAT0, 8'h0, 64'd0, 64'd0, 2'd0, 4'd0);
    add_entry(OP_STAT1, 8'h0, 64'd0, 64'd0, 2'd0, 4'd0);
    add_entry(OP_RD, `REG_ID0, 64'd0, 64'(`CL_ID0), `RESP_OKAY, 4'd0);
    add_entry(OP_RD, `REG_ID1, 64'd0, 64'(`CL_ID1), `RESP_OKAY, 4'd0);
    // DIP switches
    add_entry(OP_VDIP, 8'h0, 64'(vdip_r), 64'd0, 2'd0, 4'd0);
    add_entry(OP_RD, `REG_VDIP, 64'd0, 64'(vdip_r), `RESP_OKAY, 4'd0);
    // LED control
    add_entry(OP_WR, `REG_CTRL, 64'(ctrl_on), 64'd0, `RESP_OKAY, 4'd0);
    add_entry(OP_VLED, 8'h0, 64'd0, 64'(led_r), 2'd0, 4'd0);
    add_entry(OP_STAT0, 8'h0, 64'd0, 64'(ctrl_on), 2'd0, 4'd0);
    add_entry(OP_RD, `REG_CTRL, 64'd0, 64'(ctrl_on), `RESP_OKAY, 4'd0);
    add_entry(OP_WR, `REG_CTRL, 64'(ctrl_off), 64'd0, `RESP_OKAY, 4'd0);
    add_entry(OP_VLED, 8'h0, 64'd0, 64'(`CL_VLED_DEFAULT), 2'd0, 4'd0);
    add_entry(OP_STAT0, 8'h0, 64'd0, 64'(ctrl_off), 2'd0, 4'd0);
    // Scratch
    add_entry(OP_WR, `REG_SCRATCH, 64'(scr[0]), 64'd0, `RESP_OKAY, 4'd0);
    add_entry(OP_RD, `REG_SCRATCH, 64'd0, 64'(scr[0]), `RESP_OKAY, 4'd0);
    add_entry(OP_STAT1, 8'h0, 64'd0, 64'(scr[0]), 2'd0, 4'd0);
    add_entry(OP_WR, `REG_SCRATCH, 64'(scr[1]), 64'd0, `RESP_OKAY, 4'd0);
    add_entry(OP_RD, `REG_SCRATCH, 64'd0, 64'(scr[1]), `RESP_OKAY, 4'd0);
    add_entry(OP_STAT1, 8'h0, 64'd0, 64'(scr[1]), 2'd0, 4'd0);
    // Global counter halves
    add_entry(OP_GLC, 8'h0, glc_r, 64'd0, 2'd0, 4'd0);
    add_entry(OP_RD, `REG_GLC_LO, 64'd0, 64'(glc_r[31:0]), `RESP_OKAY, 4'd0);
    add_entry(OP_RD, `REG_GLC_HI, 64'd0, 64'(glc_r[63:32]), `RESP_OKAY, 4'd0);
    // Unmapped and read-only offsets leave the registers alone
    add_entry(OP_WR, 8'h20, 64'(scr[2]), 64'd0, `RESP_SLVERR, 4'd0);
    add_entry(OP_WR, `REG_ID0, 64'(scr[2]), 64'd0, `RESP_SLVERR, 4'd0);
    add_entry(OP_RD, 8'h20, 64'd0, 64'd0, `RESP_SLVERR, 4'd0);
    add_entry(OP_STAT0, 8'h0, 64'd0, 64'(ctrl_off), 2'd0, 4'd0);
    add_entry(OP_STAT1, 8'h0, 64'd0, 64'(scr[1]), 2'd0, 4'd0);
    // Host back-pressure on both response channels
    add_entry(OP_WR, `REG_SCRATCH, 64'(scr[2]), 64'd0, `RESP_OKAY, 4'd5);
    add_entry(OP_RD, `REG_SCRATCH, 64'd0, 64'(scr[2]), `RESP_OKAY, 4'd6);
    add_entry(OP_RD, `REG_ID1, 64'd0, 64'(`CL_ID1), `RESP_OKAY, 4'd4);
    add_entry(OP_STAT1, 8'h0, 64'd0, 64'(scr[2]), 2'd0, 4'd0);

    cnt = 0;
    while (rst_n !== 1'b1) begin
      cnt++;
      if (cnt > TIMEOUT) timeout_fail("reset release");
      @(posedge clk);
    end
    // Two edges through the synchronizer, one spare
    wait_cycles(3);
    @(negedge clk);
    check_value("aw_ready", 64'(rsp.aw_ready), 64'd0);
    check_value("ar_ready", 64'(rsp.ar_ready), 64'd0);
    check_value("b_valid", 64'(rsp.b_valid), 64'd0);
    check_value("r_valid", 64'(rsp.r_valid), 64'd0);

    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end

    wait_cycles(2);
    $display("All checks passed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+design
design/cl_core_pkg.sv
design/cl_rst_sync.sv
design/cl_status_regs.sv
design/cl_ocl_slave.sv
design/cl_core_top.sv
verif/tb_clk_gen.sv
verif/tb_cl_core.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_cl_core -o tb_cl_core \
  && ./obj_dir/tb_cl_core > sim.log 2>&1 \
  || echo "Build or simulation returned an error"
grep -q "All checks passed" sim.log && echo "Simulation passed" && exit 0
echo "Simulation failed"
exit 1
